/* rtl/cache_geom_pkg.sv */
package cache_geom_pkg;

    localparam int addr_width     = 32;
    localparam int data_width     = 32;
    localparam int words_per_line = 4;
    localparam int line_bits      = data_width * words_per_line;
    localparam int num_lines      = 16;

    // 4 KiB backing RAM, addressed in words
    localparam int ram_words      = 1024;
    localparam int ram_addr_bits  = $clog2(ram_words);

    localparam int index_bits     = $clog2(num_lines);
    localparam int word_sel_bits  = $clog2(words_per_line);

    // Tag is the part of the RAM word address above index and word select
    localparam int tag_bits       = ram_addr_bits - index_bits - word_sel_bits;

    // One APB address, seen either raw or as direct-mapped cache fields
    typedef union packed {
        logic [addr_width-1:0] raw;
        struct packed {
            logic [19:0]              upper;
            logic [tag_bits-1:0]      tag;
            logic [index_bits-1:0]    index;
            logic [word_sel_bits-1:0] word;
            logic [1:0]               byte_sel;
        } f;
    } cache_addr_t;

endpackage

/* rtl/apb_map_pkg.sv */
package apb_map_pkg;

    // RAM window, base must be aligned to the window size
    localparam logic [31:0] ram_base       = 32'h0000_0000;
    localparam logic [31:0] ram_limit      = 32'h0000_0FFF;

    // Read-only statistics registers
    localparam logic [31:0] stat_hit_addr  = 32'h0001_0000;
    localparam logic [31:0] stat_miss_addr = 32'h0001_0004;

    typedef enum logic [2:0] {
        acc_none,
        acc_ram_read,
        acc_ram_write,
        acc_stat_hit,
        acc_stat_miss,
        acc_error
    } access_kind_t;

endpackage

/* rtl/access_decode.sv */
`timescale 1ns/1ps

module access_decode (
    input  logic                                     psel,
    input  logic                                     penable,
    input  logic                                     pwrite,
    input  cache_geom_pkg::cache_addr_t              paddr,
    input  logic [cache_geom_pkg::tag_bits-1:0]      lookup_tag,
    input  logic                                     lookup_valid,
    input  logic                                     fill_busy,
    output apb_map_pkg::access_kind_t                kind,
    output logic                                     lookup_hit,
    output logic [cache_geom_pkg::index_bits-1:0]    addr_index,
    output logic [cache_geom_pkg::tag_bits-1:0]      addr_tag,
    output logic [cache_geom_pkg::word_sel_bits-1:0] addr_word
);
    import apb_map_pkg::*;

    logic in_ram;

    // Field view of the address feeds the cache lookup
    assign addr_index = paddr.f.index;
    assign addr_tag   = paddr.f.tag;
    assign addr_word  = paddr.f.word;

    // Window check on the raw view
    assign in_ram = (paddr.raw & ~ram_limit) == ram_base;

    assign lookup_hit = in_ram && lookup_valid && (lookup_tag == paddr.f.tag);

    always_comb begin
        kind = acc_none;
        if (fill_busy) begin
            // A running miss owns the port until the fill is done
            kind = acc_ram_read;
        end else if (psel && penable) begin
            if (in_ram) begin
                if (pwrite) begin
                    kind = acc_ram_write;
                end else begin
                    kind = acc_ram_read;
                end
            end else if (!pwrite && paddr.raw == stat_hit_addr) begin
                kind = acc_stat_hit;
            end else if (!pwrite && paddr.raw == stat_miss_addr) begin
                kind = acc_stat_miss;
            end else begin
                // Unmapped, or a write to a counter
                kind = acc_error;
            end
        end
    end

endmodule

/* rtl/line_cache.sv */
`timescale 1ns/1ps

module line_cache (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic [cache_geom_pkg::index_bits-1:0]    lookup_index,
    input  logic                                     wr_en,
    input  logic [cache_geom_pkg::index_bits-1:0]    wr_index,
    input  logic [cache_geom_pkg::word_sel_bits-1:0] wr_word,
    input  logic [cache_geom_pkg::data_width-1:0]    wr_data,
    input  logic                                     fill_en,
    input  logic [cache_geom_pkg::index_bits-1:0]    fill_index,
    input  logic [cache_geom_pkg::tag_bits-1:0]      fill_tag,
    input  logic [cache_geom_pkg::line_bits-1:0]     fill_line,
    output logic [cache_geom_pkg::tag_bits-1:0]      lookup_tag,
    output logic                                     lookup_valid,
    output logic [cache_geom_pkg::line_bits-1:0]     lookup_line
);
    import cache_geom_pkg::*;

    // Word 0 of a line sits in the low bits
    logic [words_per_line-1:0][data_width-1:0] data_mem [num_lines];
    logic [tag_bits-1:0]                       tag_mem  [num_lines];
    logic [num_lines-1:0]                      valid;

    // Lookup is purely combinational on the current index
    assign lookup_line  = data_mem[lookup_index];
    assign lookup_tag   = tag_mem[lookup_index];
    assign lookup_valid = valid[lookup_index];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (fill_en) begin
            valid[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            data_mem[fill_index] <= fill_line;
            tag_mem[fill_index]  <= fill_tag;
        end else if (wr_en) begin
            // Write hit, only one word of a present line changes
            data_mem[wr_index][wr_word] <= wr_data;
        end
    end

endmodule

/* rtl/miss_fill.sv */
`timescale 1ns/1ps

module miss_fill (
    input  logic                                                        clk,
    input  logic                                                        rst,
    input  apb_map_pkg::access_kind_t                                   kind,
    input  logic                                                        lookup_hit,
    input  logic [cache_geom_pkg::tag_bits+cache_geom_pkg::index_bits-1:0] paddr_line,
    input  logic [cache_geom_pkg::word_sel_bits-1:0]                    addr_word,
    input  logic [cache_geom_pkg::data_width-1:0]                       pwdata,
    input  logic [cache_geom_pkg::data_width-1:0]                       ram_rdata,
    output logic [cache_geom_pkg::ram_addr_bits-1:0]                    ram_addr,
    output logic                                                        ram_we,
    output logic [cache_geom_pkg::data_width-1:0]                       ram_wdata,
    output logic                                                        fill_busy,
    output logic                                                        fill_done,
    output logic                                                        fill_en,
    output logic [cache_geom_pkg::index_bits-1:0]                       fill_index,
    output logic [cache_geom_pkg::tag_bits-1:0]                         fill_tag,
    output logic [cache_geom_pkg::line_bits-1:0]                        fill_line
);
    import cache_geom_pkg::*;
    import apb_map_pkg::*;

    enum logic [1:0] {
        st_idle,
        st_issue,
        st_finish
    } state;

    logic [word_sel_bits-1:0]        cnt;
    // Lower three words of the line, the top word arrives in finish
    logic [line_bits-data_width-1:0] line_buf;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            cnt   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (kind == acc_ram_read && !lookup_hit) begin
                        state <= st_issue;
                        cnt   <= '0;
                    end
                end
                st_issue: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == 2'd3) begin
                        state <= st_finish;
                    end
                end
                st_finish: state <= st_idle;
                default:   state <= st_idle;
            endcase
        end
    end

    // Shift register, read data lags the address by one cycle so the
    // first shift drops out and words 0 to 2 remain after four shifts
    always_ff @(posedge clk) begin
        if (state == st_issue) begin
            line_buf <= {ram_rdata, line_buf[line_bits-data_width-1:data_width]};
        end
    end

    always_comb begin
        if (state == st_issue) begin
            ram_addr = {paddr_line, cnt};
        end else begin
            ram_addr = {paddr_line, addr_word};
        end
    end

    // Write-through happens in the first access cycle
    assign ram_we    = (state == st_idle) && (kind == acc_ram_write);
    assign ram_wdata = pwdata;

    assign fill_busy  = (state != st_idle);
    assign fill_done  = (state == st_finish);
    assign fill_en    = fill_done;
    assign fill_index = paddr_line[index_bits-1:0];
    assign fill_tag   = paddr_line[tag_bits+index_bits-1:index_bits];
    assign fill_line  = {ram_rdata, line_buf};

endmodule

/* rtl/resp_select.sv */
`timescale 1ns/1ps

module resp_select (
    input  logic                                     clk,
    input  logic                                     rst,
    input  apb_map_pkg::access_kind_t                kind,
    input  logic                                     lookup_hit,
    input  logic [cache_geom_pkg::line_bits-1:0]     lookup_line,
    input  logic [cache_geom_pkg::word_sel_bits-1:0] addr_word,
    input  logic                                     fill_done,
    input  logic [cache_geom_pkg::line_bits-1:0]     fill_line,
    output logic [cache_geom_pkg::data_width-1:0]    prdata,
    output logic                                     pready,
    output logic                                     pslverr
);
    import cache_geom_pkg::*;
    import apb_map_pkg::*;

    logic [data_width-1:0] hit_count;
    logic [data_width-1:0] miss_count;
    logic                  read_hit;

    assign read_hit = (kind == acc_ram_read) && lookup_hit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            if (read_hit) begin
                hit_count <= hit_count + 1'b1;
            end
            if (fill_done) begin
                miss_count <= miss_count + 1'b1;
            end
        end
    end

    always_comb begin
        prdata = '0;
        case (kind)
            acc_ram_read: begin
                if (fill_done) begin
                    prdata = fill_line[addr_word*data_width +: data_width];
                end else begin
                    prdata = lookup_line[addr_word*data_width +: data_width];
                end
            end
            acc_stat_hit:  prdata = hit_count;
            acc_stat_miss: prdata = miss_count;
            default:       prdata = '0;
        endcase
    end

    // Only a read miss waits, everything else completes at once
    assign pready  = (kind == acc_ram_read) ? (lookup_hit || fill_done) : (kind != acc_none);
    assign pslverr = (kind == acc_error);

endmodule

/* rtl/backing_ram.sv */
`timescale 1ns/1ps

module backing_ram (
    input  logic        clk,
    input  logic [9:0]  addr,
    input  logic        we,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);

    // 1024 words, 4 KiB
    logic [31:0] mem [0:1023];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        // Registered read returns the old word on a same-cycle write
        rdata <= mem[addr];
    end

endmodule

/* rtl/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [cache_geom_pkg::addr_width-1:0] paddr,
    input  logic [cache_geom_pkg::data_width-1:0] pwdata,
    output logic [cache_geom_pkg::data_width-1:0] prdata,
    output logic                                  pready,
    output logic                                  pslverr
);
    import cache_geom_pkg::*;
    import apb_map_pkg::*;

    access_kind_t             kind;
    logic                     lookup_hit;
    logic [index_bits-1:0]    addr_index;
    logic [tag_bits-1:0]      addr_tag;
    logic [word_sel_bits-1:0] addr_word;
    logic [tag_bits-1:0]      lookup_tag;
    logic                     lookup_valid;
    logic [line_bits-1:0]     lookup_line;
    logic                     fill_busy;
    logic                     fill_done;
    logic                     fill_en;
    logic [index_bits-1:0]    fill_index;
    logic [tag_bits-1:0]      fill_tag;
    logic [line_bits-1:0]     fill_line;
    logic [ram_addr_bits-1:0] ram_addr;
    logic                     ram_we;
    logic [data_width-1:0]    ram_wdata;
    logic [data_width-1:0]    ram_rdata;

    access_decode u_decode (
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .lookup_tag   (lookup_tag),
        .lookup_valid (lookup_valid),
        .fill_busy    (fill_busy),
        .kind         (kind),
        .lookup_hit   (lookup_hit),
        .addr_index   (addr_index),
        .addr_tag     (addr_tag),
        .addr_word    (addr_word)
    );

    // Write hit updates the cached word, a write miss leaves the cache alone
    line_cache u_cache (
        .clk          (clk),
        .rst          (rst),
        .lookup_index (addr_index),
        .wr_en        ((kind == acc_ram_write) && lookup_hit),
        .wr_index     (addr_index),
        .wr_word      (addr_word),
        .wr_data      (pwdata),
        .fill_en      (fill_en),
        .fill_index   (fill_index),
        .fill_tag     (fill_tag),
        .fill_line    (fill_line),
        .lookup_tag   (lookup_tag),
        .lookup_valid (lookup_valid),
        .lookup_line  (lookup_line)
    );

    miss_fill u_fill (
        .clk        (clk),
        .rst        (rst),
        .kind       (kind),
        .lookup_hit (lookup_hit),
        .paddr_line ({addr_tag, addr_index}),
        .addr_word  (addr_word),
        .pwdata     (pwdata),
        .ram_rdata  (ram_rdata),
        .ram_addr   (ram_addr),
        .ram_we     (ram_we),
        .ram_wdata  (ram_wdata),
        .fill_busy  (fill_busy),
        .fill_done  (fill_done),
        .fill_en    (fill_en),
        .fill_index (fill_index),
        .fill_tag   (fill_tag),
        .fill_line  (fill_line)
    );

    resp_select u_resp (
        .clk         (clk),
        .rst         (rst),
        .kind        (kind),
        .lookup_hit  (lookup_hit),
        .lookup_line (lookup_line),
        .addr_word   (addr_word),
        .fill_done   (fill_done),
        .fill_line   (fill_line),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr)
    );

    backing_ram u_ram (
        .clk   (clk),
        .addr  (ram_addr),
        .we    (ram_we),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

/* sim/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
    output logic clk
);

    // 20 ns period
    localparam time half_period = 10ns;

    initial begin
        clk = 1'b0;
    end

    always #(half_period) clk = ~clk;

endmodule

/* sim/mem_tb.sv */
`timescale 1ns/1ps

module mem_tb;
    import apb_map_pkg::*;

    localparam int reset_cycles   = 16;
    localparam int max_xfers      = 2000;
    localparam int xfer_cycles    = 7;
    localparam int timeout_cycles = max_xfers * xfer_cycles + 6000;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // Reference model, cached data always equals RAM under write-through
    logic [31:0] ref_mem [0:1023];
    logic [3:0]  ref_tag [0:15];
    logic [15:0] ref_valid;
    logic [31:0] model_hits;
    logic [31:0] model_misses;
    int          cycle_count;

    // Four cache indices shared by four tags, so lines keep evicting each other
    logic [3:0]  index_pool [4] = '{4'd1, 4'd2, 4'd5, 4'd9};
    logic [3:0]  tag_pool   [4] = '{4'd0, 4'd3, 4'd7, 4'd12};

    clk_gen u_clk (.clk(clk));

    mem_subsys_top DUT (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout, the run did not finish within %0d cycles", timeout_cycles);
            $display("test failed");
            $fatal(1, "simulation stopped at the cycle limit");
        end
    end

    function automatic logic [31:0] line_addr(input logic [3:0] tag, input logic [3:0] index,
                                              input logic [1:0] word);
        line_addr = {20'h0, tag, index, word, 2'b00};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("test failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic model_read(input logic [31:0] addr, output logic [31:0] data,
                              output logic hit);
        hit  = ref_valid[addr[7:4]] && (ref_tag[addr[7:4]] == addr[11:8]);
        data = ref_mem[addr[11:2]];
        if (hit) begin
            model_hits = model_hits + 32'd1;
        end else begin
            // Miss allocates the whole line
            ref_valid[addr[7:4]] = 1'b1;
            ref_tag[addr[7:4]]   = addr[11:8];
            model_misses         = model_misses + 32'd1;
        end
    endtask

    // One APB transfer, sampled 5 ns after the falling edge
    task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err,
                            output logic [31:0] waits);
        waits = 32'd0;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #5;
        while (!pready) begin
            @(negedge clk);
            #5;
            waits = waits + 32'd1;
        end
        rdata = prdata;
        err   = pslverr;
    endtask

    task automatic write_word(input string name, input logic [31:0] addr,
                              input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        logic [31:0] waits;
        apb_xfer(1'b1, addr, data, rdata, err, waits);
        ref_mem[addr[11:2]] = data;
        check_value({name, " pslverr"}, 32'd0, {31'd0, err});
        check_value({name, " wait states"}, 32'd0, waits);
    endtask

    task automatic read_word(input string name, input logic [31:0] addr);
        logic [31:0] expected;
        logic        hit;
        logic [31:0] rdata;
        logic        err;
        logic [31:0] waits;
        model_read(addr, expected, hit);
        apb_xfer(1'b0, addr, 32'h0, rdata, err, waits);
        check_value(name, expected, rdata);
        check_value({name, " pslverr"}, 32'd0, {31'd0, err});
        // Miss waits for four RAM reads plus the return of the last word
        check_value({name, " wait states"}, hit ? 32'd0 : 32'd5, waits);
    endtask

    task automatic read_stat(input string name, input logic [31:0] addr,
                             input logic [31:0] expected);
        logic [31:0] rdata;
        logic        err;
        logic [31:0] waits;
        apb_xfer(1'b0, addr, 32'h0, rdata, err, waits);
        check_value(name, expected, rdata);
        check_value({name, " pslverr"}, 32'd0, {31'd0, err});
        check_value({name, " wait states"}, 32'd0, waits);
    endtask

    task automatic error_access(input string name, input logic wr, input logic [31:0] addr);
        logic [31:0] rdata;
        logic        err;
        logic [31:0] waits;
        apb_xfer(wr, addr, 32'hdead_beef, rdata, err, waits);
        check_value({name, " pslverr"}, 32'd1, {31'd0, err});
        check_value({name, " prdata"}, 32'd0, rdata);
        check_value({name, " wait states"}, 32'd0, waits);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] addr;
        int          i;
        int          t;
        int          x;
        int          w;

        void'($urandom(32'ha80a));
        rst          = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = 32'h0;
        pwdata       = 32'h0;
        ref_valid    = '0;
        model_hits   = 32'd0;
        model_misses = 32'd0;
        cycle_count  = 0;
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;

        read_stat("hit count after reset", stat_hit_addr, 32'd0);
        read_stat("miss count after reset", stat_miss_addr, 32'd0);

        // Line never cached, so the writes only reach RAM
        for (w = 0; w < 4; w++) begin
            write_word("write no allocate", line_addr(4'd6, 4'd12, w[1:0]), $urandom);
        end
        read_word("read after write miss", line_addr(4'd6, 4'd12, 2'd1));
        read_word("read same line", line_addr(4'd6, 4'd12, 2'd2));
        read_stat("miss count after fill", stat_miss_addr, model_misses);
        read_stat("hit count after fill", stat_hit_addr, model_hits);

        // Give every word of the pool lines a known value
        for (t = 0; t < 4; t++) begin
            for (x = 0; x < 4; x++) begin
                for (w = 0; w < 4; w++) begin
                    write_word("prefill", line_addr(tag_pool[t], index_pool[x], w[1:0]),
                               $urandom);
                end
            end
        end

        for (i = 0; i < 600; i++) begin
            r    = $urandom;
            addr = line_addr(tag_pool[r[3:2]], index_pool[r[1:0]], r[5:4]);
            if (r[6]) begin
                write_word("random write", addr, $urandom);
            end else begin
                read_word("random read", addr);
            end
        end

        read_stat("hit count after random", stat_hit_addr, model_hits);
        read_stat("miss count after random", stat_miss_addr, model_misses);

        error_access("read above window", 1'b0, 32'h0000_1000);
        // Low bits alias word 0 of a pool line that the readback fetches from RAM
        error_access("write above window", 1'b1, 32'h0000_2310);
        error_access("read past counters", 1'b0, 32'h0001_0008);
        error_access("write to hit counter", 1'b1, stat_hit_addr);
        error_access("read top address", 1'b0, 32'hffff_fffc);

        read_stat("hit count after errors", stat_hit_addr, model_hits);
        read_stat("miss count after errors", stat_miss_addr, model_misses);

        // Memory contents must be untouched by the error writes
        for (t = 0; t < 4; t++) begin
            for (x = 0; x < 4; x++) begin
                for (w = 0; w < 4; w++) begin
                    read_word("readback", line_addr(tag_pool[t], index_pool[x], w[1:0]));
                end
            end
        end
        read_stat("final hit count", stat_hit_addr, model_hits);
        read_stat("final miss count", stat_miss_addr, model_misses);

        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        $display("test passed");
        $finish;
    end

endmodule

/* sources.f */
rtl/cache_geom_pkg.sv
rtl/apb_map_pkg.sv
rtl/access_decode.sv
rtl/line_cache.sv
rtl/miss_fill.sv
rtl/resp_select.sv
rtl/backing_ram.sv
rtl/mem_subsys_top.sv
sim/clk_gen.sv
sim/mem_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator from the file list, then run; a $fatal gives a nonzero status
cd "$(dirname "$0")" &&
verilator --binary --timing -f sources.f --top-module mem_tb -o mem_tb_sim &&
./obj_dir/mem_tb_sim || exit 1
